// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  alu_sel_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic [1:0]  res_src_t;

    // major opcodes of the supported subset
    localparam opcode_t op_rtype  = 7'b0110011;
    localparam opcode_t op_itype  = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;

    localparam alu_sel_t alu_add = 3'd0;
    localparam alu_sel_t alu_sub = 3'd1;
    localparam alu_sel_t alu_and = 3'd2;
    localparam alu_sel_t alu_or  = 3'd3;
    localparam alu_sel_t alu_xor = 3'd4;
    localparam alu_sel_t alu_slt = 3'd5;

    localparam fwd_sel_t fwd_none = 2'b00;
    localparam fwd_sel_t fwd_wb   = 2'b01;
    localparam fwd_sel_t fwd_mem  = 2'b10;

    localparam res_src_t res_alu = 2'b00;
    localparam res_src_t res_mem = 2'b01;
    localparam res_src_t res_pc4 = 2'b10;

    // addi x0, x0, 0
    localparam xlen_t nop_instr = 32'h0000_0013;

    typedef struct packed {
        xlen_t pc;
        xlen_t pc_plus4;
        xlen_t instr;
    } if_id_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     jump;
        logic     alu_src;
        alu_sel_t alu_sel;
        res_src_t res_src;
        xlen_t    rd1;
        xlen_t    rd2;
        xlen_t    imm;
        xlen_t    pc;
        xlen_t    pc_plus4;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        res_src_t res_src;
        xlen_t    alu_result;
        xlen_t    write_data;
        xlen_t    pc_plus4;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        res_src_t res_src;
        xlen_t    alu_result;
        xlen_t    read_data;
        xlen_t    pc_plus4;
        reg_idx_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    value;
    } retire_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::xlen_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall_fd,
    input  logic           flush_d,
    input  logic           redirect,
    input  rv_pkg::xlen_t  target,
    input  rv_pkg::xlen_t  instr,
    output rv_pkg::xlen_t  pc,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    xlen_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall_fd) begin
            pc <= pc_plus4;
        end
    end

    // squashed slot becomes a nop
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            if_id.pc       <= '0;
            if_id.pc_plus4 <= '0;
            if_id.instr    <= nop_instr;
        end else if (!stall_fd) begin
            if_id.pc       <= pc;
            if_id.pc_plus4 <= pc_plus4;
            if_id.instr    <= instr;
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t ra1,
    input  rv_pkg::reg_idx_t ra2,
    input  rv_pkg::retire_t  retire,
    output rv_pkg::xlen_t    rd1,
    output rv_pkg::xlen_t    rd2
);
    import rv_pkg::*;

    // x0 has no storage
    xlen_t regs [31:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;
        end
    end

    // write-first: same-cycle write wins over stored value
    function automatic xlen_t read_port(input reg_idx_t ra);
        if (ra == '0) begin
            return '0;
        end else if (retire.valid && retire.rd == ra) begin
            return retire.value;
        end
        return regs[ra];
    endfunction

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_e,
    input  rv_pkg::if_id_t  if_id,
    input  rv_pkg::retire_t retire,
    output rv_pkg::id_ex_t  id_ex,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2
);
    import rv_pkg::*;

    xlen_t   instr;
    opcode_t opcode;
    xlen_t   imm_i;
    xlen_t   imm_s;
    xlen_t   imm_b;
    xlen_t   imm_j;
    xlen_t   rd1;
    xlen_t   rd2;
    id_ex_t  id_ex_d;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    reg_file u_rf (
        .clk(clk),
        .rst(rst),
        .ra1(rs1),
        .ra2(rs2),
        .retire(retire),
        .rd1(rd1),
        .rd2(rd2)
    );

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.rd1      = rd1;
        id_ex_d.rd2      = rd2;
        id_ex_d.pc       = if_id.pc;
        id_ex_d.pc_plus4 = if_id.pc_plus4;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = instr[11:7];
        id_ex_d.alu_sel  = alu_add;
        id_ex_d.res_src  = res_alu;
        case (opcode)
            op_rtype: begin
                id_ex_d.reg_write = 1'b1;
                case (instr[14:12])
                    3'b000:  id_ex_d.alu_sel = instr[30] ? alu_sub : alu_add;
                    3'b111:  id_ex_d.alu_sel = alu_and;
                    3'b110:  id_ex_d.alu_sel = alu_or;
                    3'b100:  id_ex_d.alu_sel = alu_xor;
                    3'b010:  id_ex_d.alu_sel = alu_slt;
                    default: id_ex_d.alu_sel = alu_add;
                endcase
            end
            op_itype: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.imm       = imm_i;
            end
            op_load: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.res_src   = res_mem;
                id_ex_d.imm       = imm_i;
            end
            op_store: begin
                id_ex_d.mem_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.imm       = imm_s;
            end
            op_branch: begin
                id_ex_d.branch = 1'b1;
                id_ex_d.imm    = imm_b;
            end
            op_jal: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.jump      = 1'b1;
                id_ex_d.res_src   = res_pc4;
                id_ex_d.imm       = imm_j;
            end
            // anything else passes as a bubble
            default: ;
        endcase
    end

    // bubble on load-use stall or redirect
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.branch    <= 1'b0;
            id_ex.jump      <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// File: exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_t  fwd_a,
    input  rv_pkg::fwd_sel_t  fwd_b,
    input  rv_pkg::xlen_t     wb_value,
    output rv_pkg::ex_mem_t   ex_mem,
    output logic              redirect,
    output rv_pkg::xlen_t     target
);
    import rv_pkg::*;

    xlen_t   src_a;
    xlen_t   fwd_rd2;
    xlen_t   src_b;
    xlen_t   alu_result;
    ex_mem_t ex_mem_d;

    function automatic xlen_t pick(input fwd_sel_t sel, input xlen_t reg_val);
        case (sel)
            fwd_mem: return ex_mem.alu_result;
            fwd_wb:  return wb_value;
            default: return reg_val;
        endcase
    endfunction

    assign src_a   = pick(fwd_a, id_ex.rd1);
    assign fwd_rd2 = pick(fwd_b, id_ex.rd2);
    assign src_b   = id_ex.alu_src ? id_ex.imm : fwd_rd2;

    always_comb begin
        case (id_ex.alu_sel)
            alu_sub: alu_result = src_a - src_b;
            alu_and: alu_result = src_a & src_b;
            alu_or:  alu_result = src_a | src_b;
            alu_xor: alu_result = src_a ^ src_b;
            alu_slt: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            default: alu_result = src_a + src_b;
        endcase
    end

    // beq and jal both go to pc + imm
    assign target   = id_ex.pc + id_ex.imm;
    assign redirect = id_ex.jump || (id_ex.branch && src_a == fwd_rd2);

    always_comb begin
        ex_mem_d.reg_write  = id_ex.reg_write;
        ex_mem_d.mem_read   = id_ex.mem_read;
        ex_mem_d.mem_write  = id_ex.mem_write;
        ex_mem_d.res_src    = id_ex.res_src;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.write_data = fwd_rd2;
        ex_mem_d.pc_plus4   = id_ex.pc_plus4;
        ex_mem_d.rd         = id_ex.rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::ex_mem_t ex_mem,
    input  rv_pkg::xlen_t   read_data,
    output rv_pkg::xlen_t   data_addr,
    output rv_pkg::xlen_t   din,
    output logic            data_we,
    output logic            data_re,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    mem_wb_t mem_wb;

    // memory answers in the same cycle
    assign data_addr = ex_mem.alu_result;
    assign din       = ex_mem.write_data;
    assign data_we   = ex_mem.mem_write;
    assign data_re   = ex_mem.mem_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.res_src    <= ex_mem.res_src;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.read_data  <= read_data;
            mem_wb.pc_plus4   <= ex_mem.pc_plus4;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    always_comb begin
        retire.valid = mem_wb.reg_write && mem_wb.rd != '0;
        retire.rd    = mem_wb.rd;
        case (mem_wb.res_src)
            res_mem: retire.value = mem_wb.read_data;
            res_pc4: retire.value = mem_wb.pc_plus4;
            default: retire.value = mem_wb.alu_result;
        endcase
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_idx_t rs1_d,
    input  rv_pkg::reg_idx_t rs2_d,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_mem_t  ex_mem,
    input  rv_pkg::retire_t  retire,
    input  logic             redirect,
    output logic             stall_fd,
    output logic             flush_d,
    output logic             flush_e,
    output rv_pkg::fwd_sel_t fwd_a,
    output rv_pkg::fwd_sel_t fwd_b
);
    import rv_pkg::*;

    logic load_use;

    // newer result in mem beats the one in wb
    function automatic fwd_sel_t fwd_for(input reg_idx_t rs);
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == rs) begin
            return fwd_mem;
        end else if (retire.valid && retire.rd == rs) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = fwd_for(id_ex.rs1);
    assign fwd_b = fwd_for(id_ex.rs2);

    // load data is not ready until wb
    assign load_use = id_ex.mem_read && id_ex.rd != '0 &&
                      (id_ex.rd == rs1_d || id_ex.rd == rs2_d);

    assign stall_fd = load_use;
    assign flush_e  = load_use || redirect;
    assign flush_d  = redirect;

endmodule

// File: riscv_pipeline.sv
`timescale 1ns/1ps

module riscv_pipeline #(
    parameter rv_pkg::xlen_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::xlen_t   instr,
    input  rv_pkg::xlen_t   read_data,
    output rv_pkg::xlen_t   pc,
    output rv_pkg::xlen_t   data_addr,
    output rv_pkg::xlen_t   din,
    output logic            data_we,
    output logic            data_re,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    logic     stall_fd;
    logic     flush_d;
    logic     flush_e;
    logic     redirect;
    xlen_t    target;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .stall_fd(stall_fd),
        .flush_d(flush_d),
        .redirect(redirect),
        .target(target),
        .instr(instr),
        .pc(pc),
        .if_id(if_id)
    );

    // register file write comes back from the retire port
    decode_stage u_decode (
        .clk(clk),
        .rst(rst),
        .flush_e(flush_e),
        .if_id(if_id),
        .retire(retire),
        .id_ex(id_ex),
        .rs1(rs1_d),
        .rs2(rs2_d)
    );

    exec_stage u_exec (
        .clk(clk),
        .rst(rst),
        .id_ex(id_ex),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .wb_value(retire.value),
        .ex_mem(ex_mem),
        .redirect(redirect),
        .target(target)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk),
        .rst(rst),
        .ex_mem(ex_mem),
        .read_data(read_data),
        .data_addr(data_addr),
        .din(din),
        .data_we(data_we),
        .data_re(data_re),
        .retire(retire)
    );

    hazard_unit u_hazard (
        .rs1_d(rs1_d),
        .rs2_d(rs2_d),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .retire(retire),
        .redirect(redirect),
        .stall_fd(stall_fd),
        .flush_d(flush_d),
        .flush_e(flush_e),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

endmodule

// File: riscv_pipeline_chk.sv
`timescale 1ns/1ps

module riscv_pipeline_chk (
    input logic            clk,
    input logic            rst,
    input logic            data_we,
    input logic            data_re,
    input rv_pkg::retire_t retire
);

    logic [3:0] since_rst;
    int         error_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= '0;
        end else if (since_rst != 4'd15) begin
            since_rst <= since_rst + 4'd1;
        end
    end

    // first instruction reaches mem three edges after reset, wb four
    assert property (@(posedge clk) disable iff (rst)
        since_rst < 4'd3 |-> !data_we && !data_re)
    else begin
        $error("data memory accessed before any instruction could reach it");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        since_rst < 4'd4 |-> !retire.valid)
    else begin
        $error("retire seen before any instruction could reach write-back");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.rd != 5'd0)
    else begin
        $error("retire reported for x0");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        !(data_we && data_re))
    else begin
        $error("data memory read and write in the same cycle");
        error_count++;
    end

endmodule

// File: tb_riscv_pipeline.sv
`timescale 1ns/1ps

module tb_riscv_pipeline;
    import rv_pkg::*;

    localparam int prog_len   = 24;
    localparam int rom_words  = 32;
    localparam int max_cycles = 4 * prog_len + 40;

    logic    clk;
    logic    rst;
    xlen_t   instr;
    xlen_t   read_data;
    xlen_t   pc;
    xlen_t   data_addr;
    xlen_t   din;
    logic    data_we;
    logic    data_re;
    retire_t retire;

    xlen_t    rom [rom_words];
    xlen_t    dmem [16];
    integer   seed;
    int       cycles;
    reg_idx_t exp_rd [$];
    xlen_t    exp_value [$];
    xlen_t    exp_st_addr [$];
    xlen_t    exp_st_data [$];
    xlen_t    exp_ld_addr [$];
    reg_idx_t want_rd;
    xlen_t    want_value;
    xlen_t    want_addr;
    xlen_t    want_data;

    riscv_pipeline #(
        .reset_pc(32'd0)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .read_data(read_data),
        .pc(pc),
        .data_addr(data_addr),
        .din(din),
        .data_we(data_we),
        .data_re(data_re),
        .retire(retire)
    );

    bind riscv_pipeline riscv_pipeline_chk u_chk (
        .clk(clk),
        .rst(rst),
        .data_we(data_we),
        .data_re(data_re),
        .retire(retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ROM and data memory answer in the same cycle
    assign instr     = (pc < 32'(4 * rom_words)) ? rom[pc[6:2]] : nop_instr;
    assign read_data = dmem[data_addr[5:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[5:2]] = din;
        end
    end

    function automatic xlen_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic xlen_t i_type(input opcode_t op, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic xlen_t b_type(input reg_idx_t rs1, input reg_idx_t rs2,
                                     input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic xlen_t j_type(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic load_program();
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = nop_instr;
        end
        rom[0]  = i_type(op_itype, 3'b000, 5'd1, 5'd0, 12'd5);
        rom[1]  = i_type(op_itype, 3'b000, 5'd2, 5'd0, 12'hffd);
        rom[2]  = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        rom[3]  = r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
        rom[4]  = r_type(7'h00, 3'b111, 5'd5, 5'd3, 5'd4);
        rom[5]  = r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
        rom[6]  = r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd5);
        rom[7]  = r_type(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
        rom[8]  = s_type(5'd7, 5'd0, 12'd12);
        rom[9]  = i_type(op_load, 3'b010, 5'd9, 5'd0, 12'd8);
        // load-use on x9
        rom[10] = r_type(7'h00, 3'b000, 5'd10, 5'd9, 5'd8);
        rom[11] = i_type(op_load, 3'b010, 5'd11, 5'd0, 12'd12);
        rom[12] = b_type(5'd1, 5'd1, 13'd12);
        rom[13] = i_type(op_itype, 3'b000, 5'd12, 5'd0, 12'd1);
        rom[14] = i_type(op_itype, 3'b000, 5'd13, 5'd0, 12'd2);
        rom[15] = b_type(5'd1, 5'd2, 13'd8);
        rom[16] = i_type(op_itype, 3'b000, 5'd14, 5'd11, 12'd7);
        rom[17] = j_type(5'd15, 21'd12);
        rom[18] = i_type(op_itype, 3'b000, 5'd12, 5'd0, 12'd3);
        rom[19] = i_type(op_itype, 3'b000, 5'd13, 5'd0, 12'd4);
        rom[20] = r_type(7'h00, 3'b000, 5'd16, 5'd15, 5'd14);
        rom[21] = i_type(op_itype, 3'b000, 5'd17, 5'd0, 12'd16);
        rom[22] = s_type(5'd16, 5'd17, 12'd4);
        rom[23] = i_type(op_load, 3'b010, 5'd18, 5'd0, 12'd20);
    endtask

    // preloads data memory and runs the program in ISA order
    task automatic build_expected();
        xlen_t regs [32];
        xlen_t mem [16];
        xlen_t cur_pc;
        xlen_t next_pc;
        xlen_t ins;
        xlen_t a;
        xlen_t b;
        xlen_t res;
        xlen_t addr;
        xlen_t imm_i;
        xlen_t imm_s;
        xlen_t imm_b;
        xlen_t imm_j;
        xlen_t fill;
        logic  writes;
        int    steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            fill    = $random(seed);
            mem[i]  = fill;
            dmem[i] = fill;
        end
        cur_pc = '0;
        steps  = 0;
        while (cur_pc < 32'(4 * prog_len) && steps < 100) begin
            ins     = rom[cur_pc[6:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = cur_pc + 32'd4;
            writes  = 1'b1;
            res     = '0;
            case (ins[6:0])
                op_rtype: begin
                    case ({ins[30], ins[14:12]})
                        4'b1000: res = a - b;
                        4'b0111: res = a & b;
                        4'b0110: res = a | b;
                        4'b0100: res = a ^ b;
                        4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                end
                op_itype: res = a + imm_i;
                op_load: begin
                    addr = a + imm_i;
                    res  = mem[addr[5:2]];
                    exp_ld_addr.push_back(addr);
                end
                op_store: begin
                    addr           = a + imm_s;
                    mem[addr[5:2]] = b;
                    writes         = 1'b0;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                op_branch: begin
                    writes = 1'b0;
                    if (a == b) begin
                        next_pc = cur_pc + imm_b;
                    end
                end
                op_jal: begin
                    res     = cur_pc + 32'd4;
                    next_pc = cur_pc + imm_j;
                end
                default: writes = 1'b0;
            endcase
            if (writes && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_value.push_back(res);
            end
            cur_pc = next_pc;
            steps++;
        end
    endtask

    task automatic announce_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
    endtask

    task automatic report_mismatch(input string name, input xlen_t expected,
                                   input xlen_t actual);
        announce_failure($sformatf("CHECK FAILED at %0t: %s expected %h, actual %h",
                                   $time, name, expected, actual));
    endtask

    // mid-cycle sampling of the retire and memory ports
    always @(negedge clk) begin
        if (UUT.u_chk.error_count != 0) begin
            announce_failure("a bound assertion on the DUT ports failed");
            $fatal(1);
        end
        if (!rst && retire.valid) begin
            if (exp_rd.size() == 0) begin
                announce_failure($sformatf("retire to x%0d at %0t was not expected",
                                           retire.rd, $time));
                $fatal(1);
            end else begin
                want_rd    = exp_rd.pop_front();
                want_value = exp_value.pop_front();
                assert (retire.rd == want_rd) else begin
                    report_mismatch("retire.rd", 32'(want_rd), 32'(retire.rd));
                    $fatal(1);
                end
                assert (retire.value == want_value) else begin
                    report_mismatch("retire.value", want_value, retire.value);
                    $fatal(1);
                end
            end
        end
        if (!rst && data_we) begin
            if (exp_st_addr.size() == 0) begin
                announce_failure($sformatf("store at %0t was not expected", $time));
                $fatal(1);
            end else begin
                want_addr = exp_st_addr.pop_front();
                want_data = exp_st_data.pop_front();
                assert (data_addr == want_addr) else begin
                    report_mismatch("data_addr", want_addr, data_addr);
                    $fatal(1);
                end
                assert (din == want_data) else begin
                    report_mismatch("din", want_data, din);
                    $fatal(1);
                end
            end
        end
        if (!rst && data_re) begin
            if (exp_ld_addr.size() == 0) begin
                announce_failure($sformatf("load at %0t was not expected", $time));
                $fatal(1);
            end else begin
                want_addr = exp_ld_addr.pop_front();
                assert (data_addr == want_addr) else begin
                    report_mismatch("data_addr", want_addr, data_addr);
                    $fatal(1);
                end
            end
        end
    end

    initial begin
        rst    = 1'b1;
        cycles = 0;
        seed   = 32'h69a864a7;
        load_program();
        build_expected();
        repeat (16) @(posedge clk);
        #2;
        assert (pc == 32'd0) else begin
            report_mismatch("pc", 32'd0, pc);
            $fatal(1);
        end
        rst = 1'b0;
        while (exp_rd.size() != 0 || exp_st_addr.size() != 0 ||
               exp_ld_addr.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                announce_failure($sformatf("timeout after %0d cycles, %0d retires missing",
                                           cycles, exp_rd.size()));
                $fatal(1);
            end
        end
        repeat (4) @(posedge clk);
        if (UUT.u_chk.error_count != 0) begin
            announce_failure("a bound assertion on the DUT ports failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: flist.f
rv_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
mem_wb_stage.sv
hazard_unit.sv
riscv_pipeline.sv
riscv_pipeline_chk.sv
tb_riscv_pipeline.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_riscv_pipeline \
    -f flist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
